//--- list.f
src/id_pkg.sv
src/regfile.sv
src/decode_reg.sv
src/inst_decoder.sv
src/operand_bypass.sv
src/branch_unit.sv
src/id_stage.sv
verif/tb_id_stage.sv

//--- Bender.yml
package:
  name: id_stage

sources:
  - src/id_pkg.sv
  - src/regfile.sv
  - src/decode_reg.sv
  - src/inst_decoder.sv
  - src/operand_bypass.sv
  - src/branch_unit.sv
  - src/id_stage.sv
  - target: test
    files:
      - verif/tb_id_stage.sv

//--- verif/id_stage_vectors.txt
# W addr data | I pc inst ex_we ex_a ex_d mem_we mem_a mem_d
# then alu src1 src2 rf_we waddr mem_en mem_we mem_to_rf rs rt taken target
W 01 00000011
W 02 00000022
W 03 ffffff00
W 1f 12345678
W 00 deadbeef
I 00400000 00222021 0 00 00000000 0 00 00000000 0 0 0 1 04 0 0 0 00000011 00000022 0 00408088
I 00400004 00412823 0 00 00000000 0 00 00000000 1 0 0 1 05 0 0 0 00000022 00000011 0 0040a094
I 00400008 0061302a 0 00 00000000 0 00 00000000 2 0 0 1 06 0 0 0 ffffff00 00000011 0 0040c0b4
I 0040000c 0061382b 0 00 00000000 0 00 00000000 3 0 0 1 07 0 0 0 ffffff00 00000011 0 0040e0bc
I 00400010 00224024 0 00 00000000 0 00 00000000 4 0 0 1 08 0 0 0 00000011 00000022 0 004100a4
I 00400014 00224825 0 00 00000000 0 00 00000000 5 0 0 1 09 0 0 0 00000011 00000022 0 004120ac
I 00400018 00225026 0 00 00000000 0 00 00000000 6 0 0 1 0a 0 0 0 00000011 00000022 0 004140b4
I 0040001c 00225827 0 00 00000000 0 00 00000000 7 0 0 1 0b 0 0 0 00000011 00000022 0 004160bc
I 00400020 00026100 0 00 00000000 0 00 00000000 8 2 0 1 0c 0 0 0 00000000 00000022 0 00418424
I 00400024 00026842 0 00 00000000 0 00 00000000 9 2 0 1 0d 0 0 0 00000000 00000022 0 0041a130
I 00400028 00037203 0 00 00000000 0 00 00000000 a 2 0 1 0e 0 0 0 00000000 ffffff00 0 0041c838
I 0040002c 242fffff 0 00 00000000 0 00 00000000 0 0 1 1 0f 0 0 0 00000011 00000000 0 0040002c
I 00400030 28700005 0 00 00000000 0 00 00000000 2 0 1 1 10 0 0 0 ffffff00 00000000 0 00400048
I 00400034 2c310010 0 00 00000000 0 00 00000000 3 0 1 1 11 0 0 0 00000011 00000000 0 00400078
I 00400038 305200ff 0 00 00000000 0 00 00000000 4 0 2 1 12 0 0 0 00000022 00000000 0 00400438
I 0040003c 34338000 0 00 00000000 0 00 00000000 5 0 2 1 13 0 0 0 00000011 00000000 0 003e0040
I 00400040 38541234 0 00 00000000 0 00 00000000 6 0 2 1 14 0 0 0 00000022 00000000 0 00404914
I 00400044 3c15abcd 0 00 00000000 0 00 00000000 b 0 2 1 15 0 0 0 00000000 00000000 0 003eaf7c
I 00400048 8c360008 0 00 00000000 0 00 00000000 0 0 1 1 16 1 0 1 00000011 00000000 0 0040006c
I 0040004c ac220004 0 00 00000000 0 00 00000000 0 0 1 0 00 1 1 0 00000011 00000022 0 00400060
I 00400050 fc220000 0 00 00000000 0 00 00000000 c 0 0 0 00 0 0 0 00000011 00000022 0 00400054
I 00400054 00222001 0 00 00000000 0 00 00000000 c 0 0 0 00 0 0 0 00000011 00000022 0 0040805c
I 00400058 00222021 1 01 aaaa0001 1 02 bbbb0002 0 0 0 1 04 0 0 0 aaaa0001 bbbb0002 0 004080e0
I 0040005c 00222021 1 01 aaaa0001 1 01 bbbb0001 0 0 0 1 04 0 0 0 aaaa0001 00000022 0 004080e4
I 00400060 00222021 0 02 cccc0002 1 02 bbbb0002 0 0 0 1 04 0 0 0 00000011 bbbb0002 0 004080e8
I 00400064 00022021 1 00 deadbeef 1 00 deadbeef 0 0 0 1 04 0 0 0 00000000 00000022 0 004080ec
I 00400068 10220004 0 00 00000000 0 00 00000000 c 0 0 0 00 0 0 0 00000011 00000022 0 0040007c
I 0040006c 10220004 1 02 00000011 0 00 00000000 c 0 0 0 00 0 0 0 00000011 00000011 1 00400080
I 00400070 1422fffe 0 00 00000000 0 00 00000000 c 0 0 0 00 0 0 0 00000011 00000022 1 0040006c
I 00400074 1421fffe 0 00 00000000 0 00 00000000 c 0 0 0 00 0 0 0 00000011 00000011 0 00400070
I 00400078 08100040 0 00 00000000 0 00 00000000 c 0 0 0 00 0 0 0 00000000 00000000 1 00400100
I 0040007c 0c100080 0 00 00000000 0 00 00000000 0 1 3 1 1f 0 0 0 00000000 00000000 1 00400200
I 00400080 03e00008 0 00 00000000 0 00 00000000 c 0 0 0 00 0 0 0 12345678 00000000 1 12345678
I 00400084 03e00008 1 1f 0badf00c 0 00 00000000 c 0 0 0 00 0 0 0 0badf00c 00000000 1 0badf00c

//--- verif/tb_id_stage.sv
module tb_id_stage;
    timeunit 1ns;
    timeprecision 1ps;

    localparam logic [id_pkg::XLEN-1:0] RESET_PC = 32'hbfc0_0380;

    logic                          clk;
    logic                          rst;
    logic                          in_valid;
    logic                          in_ready;
    logic [id_pkg::XLEN-1:0]       in_pc;
    logic [id_pkg::XLEN-1:0]       in_inst;
    logic                          ex_we;
    logic [id_pkg::REG_ADDR_W-1:0] ex_waddr;
    logic [id_pkg::XLEN-1:0]       ex_wdata;
    logic                          mem_we;
    logic [id_pkg::REG_ADDR_W-1:0] mem_waddr;
    logic [id_pkg::XLEN-1:0]       mem_wdata;
    logic                          wb_we;
    logic [id_pkg::REG_ADDR_W-1:0] wb_waddr;
    logic [id_pkg::XLEN-1:0]       wb_wdata;
    logic                          out_valid;
    logic                          out_ready;
    logic [id_pkg::XLEN-1:0]       out_pc;
    logic [id_pkg::XLEN-1:0]       out_inst;
    id_pkg::alu_op_e               out_alu_op;
    id_pkg::src1_sel_e             out_src1_sel;
    id_pkg::src2_sel_e             out_src2_sel;
    logic [id_pkg::XLEN-1:0]       out_rs_data;
    logic [id_pkg::XLEN-1:0]       out_rt_data;
    logic                          out_rf_we;
    logic [id_pkg::REG_ADDR_W-1:0] out_rf_waddr;
    logic                          out_mem_en;
    logic                          out_mem_we;
    logic                          out_mem_to_rf;
    logic                          br_taken;
    logic [id_pkg::XLEN-1:0]       br_target;

    // stimulus and expected fields of the current I line
    logic [31:0] v [0:19];
    integer      seed;

    id_stage #(.RESET_PC(RESET_PC)) uut (.*);

    initial begin
        clk = 1'b0;
        forever #10 clk = ~clk;
    end

    task automatic report_failure(input string what);
        $display("%s", what);
        $display("SOME TESTS FAILED");
        $fatal(1, "run stopped at first error");
    endtask

    task automatic check_word(input string name, input logic [id_pkg::XLEN-1:0] got,
                              input logic [id_pkg::XLEN-1:0] exp);
        if (got !== exp)
            report_failure($sformatf("mismatch %s: got %h expected %h", name, got, exp));
    endtask

    task automatic check_addr(input string name, input logic [id_pkg::REG_ADDR_W-1:0] got,
                              input logic [id_pkg::REG_ADDR_W-1:0] exp);
        if (got !== exp)
            report_failure($sformatf("mismatch %s: got %h expected %h", name, got, exp));
    endtask

    task automatic check_bit(input string name, input logic got, input logic exp);
        if (got !== exp)
            report_failure($sformatf("mismatch %s: got %h expected %h", name, got, exp));
    endtask

    task automatic check_alu_op(input string name, input id_pkg::alu_op_e got,
                                input id_pkg::alu_op_e exp);
        if (got !== exp)
            report_failure($sformatf("mismatch %s: got %h expected %h", name, got, exp));
    endtask

    task automatic check_src1(input string name, input id_pkg::src1_sel_e got,
                              input id_pkg::src1_sel_e exp);
        if (got !== exp)
            report_failure($sformatf("mismatch %s: got %h expected %h", name, got, exp));
    endtask

    task automatic check_src2(input string name, input id_pkg::src2_sel_e got,
                              input id_pkg::src2_sel_e exp);
        if (got !== exp)
            report_failure($sformatf("mismatch %s: got %h expected %h", name, got, exp));
    endtask

    // everything except br_taken, which depends on out_ready
    task automatic check_payload;
        check_bit("out_valid", out_valid, 1'b1);
        check_word("out_pc", out_pc, v[0]);
        check_word("out_inst", out_inst, v[1]);
        check_alu_op("out_alu_op", out_alu_op, id_pkg::alu_op_e'(v[8][3:0]));
        check_src1("out_src1_sel", out_src1_sel, id_pkg::src1_sel_e'(v[9][1:0]));
        check_src2("out_src2_sel", out_src2_sel, id_pkg::src2_sel_e'(v[10][1:0]));
        check_bit("out_rf_we", out_rf_we, v[11][0]);
        check_addr("out_rf_waddr", out_rf_waddr, v[12][4:0]);
        check_bit("out_mem_en", out_mem_en, v[13][0]);
        check_bit("out_mem_we", out_mem_we, v[14][0]);
        check_bit("out_mem_to_rf", out_mem_to_rf, v[15][0]);
        check_word("out_rs_data", out_rs_data, v[16]);
        check_word("out_rt_data", out_rt_data, v[17]);
        check_word("br_target", br_target, v[19]);
    endtask

    task automatic wait_in_ready;
        int cycles;
        cycles = 0;
        while (!in_ready) begin
            if (cycles == 100) report_failure("in_ready stayed low for 100 cycles");
            @(negedge clk);
            #1;
            cycles++;
        end
    endtask

    task automatic wait_out_valid;
        int cycles;
        cycles = 0;
        while (!out_valid) begin
            if (cycles == 100) report_failure("out_valid never rose within 100 cycles");
            @(negedge clk);
            #1;
            cycles++;
        end
    endtask

    // preload through the writeback port
    task automatic write_back(input logic [4:0] addr, input logic [31:0] data);
        @(negedge clk);
        wb_we    = 1'b1;
        wb_waddr = addr;
        wb_wdata = data;
        @(negedge clk);
        wb_we    = 1'b0;
    endtask

    task automatic apply_instruction;
        int  stalls;
        logic left;
        @(negedge clk);
        in_valid  = 1'b1;
        in_pc     = v[0];
        in_inst   = v[1];
        ex_we     = v[2][0];
        ex_waddr  = v[3][4:0];
        ex_wdata  = v[4];
        mem_we    = v[5][0];
        mem_waddr = v[6][4:0];
        mem_wdata = v[7];
        out_ready = 1'b0;
        #1;
        wait_in_ready();
        @(posedge clk);
        @(negedge clk);
        in_valid = 1'b0;
        in_pc    = '0;
        in_inst  = '0;
        #1;
        wait_out_valid();
        stalls = 0;
        left   = 1'b0;
        while (!left) begin
            @(negedge clk);
            out_ready = $random(seed) & 1;
            #1;
            check_payload();
            check_bit("in_ready", in_ready, out_ready);
            check_bit("br_taken", br_taken, out_ready ? v[18][0] : 1'b0);
            if (out_ready) begin
                @(negedge clk);
                out_ready = 1'b0;
                #1;
                // a second copy would show up here
                check_bit("out_valid", out_valid, 1'b0);
                check_bit("br_taken", br_taken, 1'b0);
                left = 1'b1;
            end else begin
                stalls++;
                if (stalls == 100) report_failure("out_ready never sampled high in 100 cycles");
            end
        end
    endtask

    initial begin
        int    fd;
        int    n;
        string tag;
        string line;
        logic [31:0] w_addr;
        logic [31:0] w_data;
        seed      = 32'hbcac;
        rst       = 1'b1;
        in_valid  = 1'b0;
        in_pc     = '0;
        in_inst   = '0;
        ex_we     = 1'b0;
        ex_waddr  = '0;
        ex_wdata  = '0;
        mem_we    = 1'b0;
        mem_waddr = '0;
        mem_wdata = '0;
        wb_we     = 1'b0;
        wb_waddr  = '0;
        wb_wdata  = '0;
        out_ready = 1'b0;
        repeat (10) @(posedge clk);
        @(negedge clk);
        rst = 1'b0;
        #1;
        check_bit("out_valid", out_valid, 1'b0);
        check_bit("br_taken", br_taken, 1'b0);
        check_bit("out_rf_we", out_rf_we, 1'b0);
        check_bit("in_ready", in_ready, 1'b1);
        // idle register holds the reset pc with a zero instruction
        check_word("out_pc", out_pc, RESET_PC);
        check_word("out_inst", out_inst, 32'h0000_0000);

        fd = $fopen("verif/id_stage_vectors.txt", "r");
        if (fd == 0) report_failure("could not open verif/id_stage_vectors.txt");
        while (!$feof(fd)) begin
            n = $fscanf(fd, "%s", tag);
            if (n == 1) begin
                if (tag == "#") begin
                    n = $fgets(line, fd);
                end else if (tag == "W") begin
                    n = $fscanf(fd, " %h %h", w_addr, w_data);
                    if (n != 2) report_failure("malformed W line in vector file");
                    write_back(w_addr[4:0], w_data);
                end else if (tag == "I") begin
                    n = $fscanf(fd, " %h %h %h %h %h %h %h %h %h %h %h %h %h %h %h %h %h %h %h %h",
                                v[0], v[1], v[2], v[3], v[4], v[5], v[6], v[7], v[8], v[9],
                                v[10], v[11], v[12], v[13], v[14], v[15], v[16], v[17],
                                v[18], v[19]);
                    if (n != 20) report_failure("malformed I line in vector file");
                    apply_instruction();
                end else begin
                    report_failure($sformatf("unknown line tag %s in vector file", tag));
                end
            end
        end
        $fclose(fd);
        $display("ALL TESTS PASSED");
        $finish;
    end

endmodule

//--- src/id_stage.sv
module id_stage #(
    parameter logic [id_pkg::XLEN-1:0] RESET_PC = 32'hbfc0_0000
) (
    input  logic                          clk,
    input  logic                          rst,
    input  logic                          in_valid,
    output logic                          in_ready,
    input  logic [id_pkg::XLEN-1:0]       in_pc,
    input  logic [id_pkg::XLEN-1:0]       in_inst,
    input  logic                          ex_we,
    input  logic [id_pkg::REG_ADDR_W-1:0] ex_waddr,
    input  logic [id_pkg::XLEN-1:0]       ex_wdata,
    input  logic                          mem_we,
    input  logic [id_pkg::REG_ADDR_W-1:0] mem_waddr,
    input  logic [id_pkg::XLEN-1:0]       mem_wdata,
    input  logic                          wb_we,
    input  logic [id_pkg::REG_ADDR_W-1:0] wb_waddr,
    input  logic [id_pkg::XLEN-1:0]       wb_wdata,
    output logic                          out_valid,
    input  logic                          out_ready,
    output logic [id_pkg::XLEN-1:0]       out_pc,
    output logic [id_pkg::XLEN-1:0]       out_inst,
    output id_pkg::alu_op_e               out_alu_op,
    output id_pkg::src1_sel_e             out_src1_sel,
    output id_pkg::src2_sel_e             out_src2_sel,
    output logic [id_pkg::XLEN-1:0]       out_rs_data,
    output logic [id_pkg::XLEN-1:0]       out_rt_data,
    output logic                          out_rf_we,
    output logic [id_pkg::REG_ADDR_W-1:0] out_rf_waddr,
    output logic                          out_mem_en,
    output logic                          out_mem_we,
    output logic                          out_mem_to_rf,
    output logic                          br_taken,
    output logic [id_pkg::XLEN-1:0]       br_target
);

    logic [id_pkg::XLEN-1:0] rf_rdata1;
    logic [id_pkg::XLEN-1:0] rf_rdata2;
    logic                    is_beq;
    logic                    is_bne;
    logic                    is_j;
    logic                    is_jal;
    logic                    is_jr;
    logic                    fire;

    assign fire = out_valid && out_ready;

    decode_reg #(.RESET_PC(RESET_PC)) u_decode_reg (
        .clk(clk), .rst(rst),
        .in_valid(in_valid), .in_ready(in_ready), .in_pc(in_pc), .in_inst(in_inst),
        .out_valid(out_valid), .out_ready(out_ready), .out_pc(out_pc), .out_inst(out_inst)
    );

    // wb result is written here and also bypassed in the same cycle
    regfile #(.NUM_REGS(id_pkg::NUM_REGS)) u_regfile (
        .clk(clk), .rst(rst),
        .raddr1(out_inst[25:21]), .raddr2(out_inst[20:16]),
        .rdata1(rf_rdata1), .rdata2(rf_rdata2),
        .we(wb_we), .waddr(wb_waddr), .wdata(wb_wdata)
    );

    inst_decoder u_inst_decoder (
        .inst(out_inst), .alu_op(out_alu_op),
        .src1_sel(out_src1_sel), .src2_sel(out_src2_sel),
        .rf_we(out_rf_we), .rf_waddr(out_rf_waddr),
        .mem_en(out_mem_en), .mem_we(out_mem_we), .mem_to_rf(out_mem_to_rf),
        .is_beq(is_beq), .is_bne(is_bne), .is_j(is_j), .is_jal(is_jal), .is_jr(is_jr)
    );

    operand_bypass u_rs_bypass (
        .raddr(out_inst[25:21]), .rf_data(rf_rdata1),
        .ex_we(ex_we), .ex_waddr(ex_waddr), .ex_wdata(ex_wdata),
        .mem_we(mem_we), .mem_waddr(mem_waddr), .mem_wdata(mem_wdata),
        .wb_we(wb_we), .wb_waddr(wb_waddr), .wb_wdata(wb_wdata),
        .data(out_rs_data)
    );

    operand_bypass u_rt_bypass (
        .raddr(out_inst[20:16]), .rf_data(rf_rdata2),
        .ex_we(ex_we), .ex_waddr(ex_waddr), .ex_wdata(ex_wdata),
        .mem_we(mem_we), .mem_waddr(mem_waddr), .mem_wdata(mem_wdata),
        .wb_we(wb_we), .wb_waddr(wb_waddr), .wb_wdata(wb_wdata),
        .data(out_rt_data)
    );

    branch_unit u_branch_unit (
        .pc(out_pc), .inst(out_inst), .rs_data(out_rs_data), .rt_data(out_rt_data),
        .is_beq(is_beq), .is_bne(is_bne), .is_j(is_j), .is_jal(is_jal), .is_jr(is_jr),
        .fire(fire), .taken(br_taken), .target(br_target)
    );

endmodule

//--- src/branch_unit.sv
module branch_unit (
    input  logic [id_pkg::XLEN-1:0] pc,
    input  logic [id_pkg::XLEN-1:0] inst,
    input  logic [id_pkg::XLEN-1:0] rs_data,
    input  logic [id_pkg::XLEN-1:0] rt_data,
    input  logic                    is_beq,
    input  logic                    is_bne,
    input  logic                    is_j,
    input  logic                    is_jal,
    input  logic                    is_jr,
    input  logic                    fire,
    output logic                    taken,
    output logic [id_pkg::XLEN-1:0] target
);

    logic [id_pkg::XLEN-1:0] pc_plus_4;
    logic [id_pkg::XLEN-1:0] br_offset;
    logic [id_pkg::XLEN-1:0] jump_addr;
    logic                    operands_eq;
    logic                    redirect;

    assign pc_plus_4   = pc + 32'd4;
    assign br_offset   = {{14{inst[15]}}, inst[15:0], 2'b00};
    // upper bits come from the delay slot pc
    assign jump_addr   = {pc_plus_4[31:28], inst[25:0], 2'b00};
    assign operands_eq = (rs_data == rt_data);

    assign redirect = (is_beq && operands_eq) || (is_bne && !operands_eq)
                      || is_j || is_jal || is_jr;

    // raised only on the handshake so fetch redirects once per branch
    assign taken = redirect && fire;

    always_comb begin
        if (is_jr) begin
            target = rs_data;
        end else if (is_j || is_jal) begin
            target = jump_addr;
        end else begin
            target = pc_plus_4 + br_offset;
        end
    end

endmodule

//--- src/operand_bypass.sv
module operand_bypass (
    input  logic [id_pkg::REG_ADDR_W-1:0] raddr,
    input  logic [id_pkg::XLEN-1:0]       rf_data,
    input  logic                          ex_we,
    input  logic [id_pkg::REG_ADDR_W-1:0] ex_waddr,
    input  logic [id_pkg::XLEN-1:0]       ex_wdata,
    input  logic                          mem_we,
    input  logic [id_pkg::REG_ADDR_W-1:0] mem_waddr,
    input  logic [id_pkg::XLEN-1:0]       mem_wdata,
    input  logic                          wb_we,
    input  logic [id_pkg::REG_ADDR_W-1:0] wb_waddr,
    input  logic [id_pkg::XLEN-1:0]       wb_wdata,
    output logic [id_pkg::XLEN-1:0]       data
);

    logic ex_hit;
    logic mem_hit;
    logic wb_hit;

    // r0 never forwards whatever a stage claims
    assign ex_hit  = ex_we && raddr != '0 && ex_waddr == raddr;
    assign mem_hit = mem_we && raddr != '0 && mem_waddr == raddr;
    assign wb_hit  = wb_we && raddr != '0 && wb_waddr == raddr;

    // youngest producer wins
    always_comb begin
        if (ex_hit) begin
            data = ex_wdata;
        end else if (mem_hit) begin
            data = mem_wdata;
        end else if (wb_hit) begin
            data = wb_wdata;
        end else begin
            data = rf_data;
        end
    end

endmodule

//--- src/inst_decoder.sv
module inst_decoder (
    input  logic [id_pkg::XLEN-1:0]       inst,
    output id_pkg::alu_op_e               alu_op,
    output id_pkg::src1_sel_e             src1_sel,
    output id_pkg::src2_sel_e             src2_sel,
    output logic                          rf_we,
    output logic [id_pkg::REG_ADDR_W-1:0] rf_waddr,
    output logic                          mem_en,
    output logic                          mem_we,
    output logic                          mem_to_rf,
    output logic                          is_beq,
    output logic                          is_bne,
    output logic                          is_j,
    output logic                          is_jal,
    output logic                          is_jr
);

    id_pkg::opcode_e                 opcode;
    id_pkg::funct_e                  funct;
    logic [id_pkg::REG_ADDR_W-1:0]   rt;
    logic [id_pkg::REG_ADDR_W-1:0]   rd;
    logic                            wr_en;

    assign opcode = id_pkg::opcode_e'(inst[31:26]);
    assign funct  = id_pkg::funct_e'(inst[5:0]);
    assign rt     = inst[20:16];
    assign rd     = inst[15:11];

    // a write to r0 is dropped here, so the reset nop carries no write
    assign rf_we = wr_en && (rf_waddr != '0);

    always_comb begin
        alu_op    = id_pkg::ALU_NONE;
        src1_sel  = id_pkg::SRC1_RS;
        src2_sel  = id_pkg::SRC2_RT;
        wr_en     = 1'b0;
        rf_waddr  = '0;
        mem_en    = 1'b0;
        mem_we    = 1'b0;
        mem_to_rf = 1'b0;
        is_beq    = 1'b0;
        is_bne    = 1'b0;
        is_j      = 1'b0;
        is_jal    = 1'b0;
        is_jr     = 1'b0;

        case (opcode)
            id_pkg::OP_SPECIAL: begin
                // register format writes rd
                wr_en    = 1'b1;
                rf_waddr = rd;
                case (funct)
                    id_pkg::FN_ADDU: alu_op = id_pkg::ALU_ADD;
                    id_pkg::FN_SUBU: alu_op = id_pkg::ALU_SUB;
                    id_pkg::FN_SLT:  alu_op = id_pkg::ALU_SLT;
                    id_pkg::FN_SLTU: alu_op = id_pkg::ALU_SLTU;
                    id_pkg::FN_AND:  alu_op = id_pkg::ALU_AND;
                    id_pkg::FN_OR:   alu_op = id_pkg::ALU_OR;
                    id_pkg::FN_XOR:  alu_op = id_pkg::ALU_XOR;
                    id_pkg::FN_NOR:  alu_op = id_pkg::ALU_NOR;
                    id_pkg::FN_SLL, id_pkg::FN_SRL, id_pkg::FN_SRA: begin
                        src1_sel = id_pkg::SRC1_SA;
                        if (funct == id_pkg::FN_SLL) begin
                            alu_op = id_pkg::ALU_SLL;
                        end else if (funct == id_pkg::FN_SRL) begin
                            alu_op = id_pkg::ALU_SRL;
                        end else begin
                            alu_op = id_pkg::ALU_SRA;
                        end
                    end
                    id_pkg::FN_JR: begin
                        wr_en = 1'b0;
                        is_jr = 1'b1;
                    end
                    default: begin
                        wr_en    = 1'b0;
                        rf_waddr = '0;
                    end
                endcase
            end
            id_pkg::OP_ADDIU, id_pkg::OP_SLTI, id_pkg::OP_SLTIU, id_pkg::OP_LW: begin
                // sign-extended immediate forms write rt
                src2_sel = id_pkg::SRC2_IMM_SEXT;
                wr_en    = 1'b1;
                rf_waddr = rt;
                case (opcode)
                    id_pkg::OP_SLTI:  alu_op = id_pkg::ALU_SLT;
                    id_pkg::OP_SLTIU: alu_op = id_pkg::ALU_SLTU;
                    default:          alu_op = id_pkg::ALU_ADD;
                endcase
                if (opcode == id_pkg::OP_LW) begin
                    mem_en    = 1'b1;
                    mem_to_rf = 1'b1;
                end
            end
            id_pkg::OP_ANDI, id_pkg::OP_ORI, id_pkg::OP_XORI, id_pkg::OP_LUI: begin
                src2_sel = id_pkg::SRC2_IMM_ZEXT;
                wr_en    = 1'b1;
                rf_waddr = rt;
                case (opcode)
                    id_pkg::OP_ANDI: alu_op = id_pkg::ALU_AND;
                    id_pkg::OP_ORI:  alu_op = id_pkg::ALU_OR;
                    id_pkg::OP_XORI: alu_op = id_pkg::ALU_XOR;
                    default:         alu_op = id_pkg::ALU_LUI;
                endcase
            end
            id_pkg::OP_SW: begin
                alu_op   = id_pkg::ALU_ADD;
                src2_sel = id_pkg::SRC2_IMM_SEXT;
                mem_en   = 1'b1;
                mem_we   = 1'b1;
            end
            id_pkg::OP_BEQ: is_beq = 1'b1;
            id_pkg::OP_BNE: is_bne = 1'b1;
            id_pkg::OP_J:   is_j   = 1'b1;
            id_pkg::OP_JAL: begin
                // link value pc + 8 skips the delay slot
                alu_op   = id_pkg::ALU_ADD;
                src1_sel = id_pkg::SRC1_PC;
                src2_sel = id_pkg::SRC2_EIGHT;
                wr_en    = 1'b1;
                rf_waddr = id_pkg::RA_REG;
                is_jal   = 1'b1;
            end
            default: ;
        endcase
    end

endmodule

//--- src/decode_reg.sv
module decode_reg #(
    parameter logic [id_pkg::XLEN-1:0] RESET_PC = '0
) (
    input  logic                    clk,
    input  logic                    rst,
    input  logic                    in_valid,
    output logic                    in_ready,
    input  logic [id_pkg::XLEN-1:0] in_pc,
    input  logic [id_pkg::XLEN-1:0] in_inst,
    output logic                    out_valid,
    input  logic                    out_ready,
    output logic [id_pkg::XLEN-1:0] out_pc,
    output logic [id_pkg::XLEN-1:0] out_inst
);

    // free when empty or when the held instruction drains this cycle
    assign in_ready = !out_valid || out_ready;

    always_ff @(posedge clk) begin
        if (rst) begin
            out_valid <= 1'b0;
            out_pc    <= RESET_PC;
            out_inst  <= '0;
        end else if (in_ready) begin
            out_valid <= in_valid;
            // payload only moves with a real transfer
            if (in_valid) begin
                out_pc   <= in_pc;
                out_inst <= in_inst;
            end
        end
    end

endmodule

//--- src/regfile.sv
module regfile #(
    parameter int NUM_REGS = id_pkg::NUM_REGS
) (
    input  logic                          clk,
    input  logic                          rst,
    input  logic [id_pkg::REG_ADDR_W-1:0] raddr1,
    input  logic [id_pkg::REG_ADDR_W-1:0] raddr2,
    output logic [id_pkg::XLEN-1:0]       rdata1,
    output logic [id_pkg::XLEN-1:0]       rdata2,
    input  logic                          we,
    input  logic [id_pkg::REG_ADDR_W-1:0] waddr,
    input  logic [id_pkg::XLEN-1:0]       wdata
);

    logic [id_pkg::XLEN-1:0] regs [NUM_REGS];

    // r0 is never written, so it stays at its reset value
    always_ff @(posedge clk) begin
        if (rst) begin
            for (int i = 0; i < NUM_REGS; i++) begin
                regs[i] <= '0;
            end
        end else if (we && waddr != '0 && waddr < NUM_REGS) begin
            regs[waddr] <= wdata;
        end
    end

    // out-of-range indices read zero on a reduced register file
    assign rdata1 = (raddr1 != '0 && raddr1 < NUM_REGS) ? regs[raddr1] : '0;
    assign rdata2 = (raddr2 != '0 && raddr2 < NUM_REGS) ? regs[raddr2] : '0;

endmodule

//--- src/id_pkg.sv
package id_pkg;

    // datapath and register file geometry
    localparam int XLEN       = 32;
    localparam int REG_ADDR_W = 5;
    localparam int NUM_REGS   = 32;

    // link register for jal
    localparam logic [REG_ADDR_W-1:0] RA_REG = 5'd31;

    // primary opcode field in inst[31:26]
    typedef enum logic [5:0] {
        OP_SPECIAL = 6'h00,
        OP_J       = 6'h02,
        OP_JAL     = 6'h03,
        OP_BEQ     = 6'h04,
        OP_BNE     = 6'h05,
        OP_ADDIU   = 6'h09,
        OP_SLTI    = 6'h0a,
        OP_SLTIU   = 6'h0b,
        OP_ANDI    = 6'h0c,
        OP_ORI     = 6'h0d,
        OP_XORI    = 6'h0e,
        OP_LUI     = 6'h0f,
        OP_LW      = 6'h23,
        OP_SW      = 6'h2b
    } opcode_e;

    // funct field of SPECIAL in inst[5:0]
    typedef enum logic [5:0] {
        FN_SLL  = 6'h00,
        FN_SRL  = 6'h02,
        FN_SRA  = 6'h03,
        FN_JR   = 6'h08,
        FN_ADDU = 6'h21,
        FN_SUBU = 6'h23,
        FN_AND  = 6'h24,
        FN_OR   = 6'h25,
        FN_XOR  = 6'h26,
        FN_NOR  = 6'h27,
        FN_SLT  = 6'h2a,
        FN_SLTU = 6'h2b
    } funct_e;

    typedef enum logic [3:0] {
        ALU_ADD,
        ALU_SUB,
        ALU_SLT,
        ALU_SLTU,
        ALU_AND,
        ALU_OR,
        ALU_XOR,
        ALU_NOR,
        ALU_SLL,
        ALU_SRL,
        ALU_SRA,
        ALU_LUI,
        ALU_NONE
    } alu_op_e;

    // first alu operand
    typedef enum logic [1:0] {
        SRC1_RS,
        SRC1_PC,
        SRC1_SA
    } src1_sel_e;

    // second alu operand
    // eight is the jal link offset
    typedef enum logic [1:0] {
        SRC2_RT,
        SRC2_IMM_SEXT,
        SRC2_IMM_ZEXT,
        SRC2_EIGHT
    } src2_sel_e;

endpackage
